// File: source/obj_defs.svh
// limits shared by RTL and testbench; table entries are 4 words, buffer is 512 wide for x wrap
`ifndef OBJ_DEFS_SVH
`define OBJ_DEFS_SVH

`define OBJ_TABLE_AW  9     // 512 words, 128 entries of 4 words
`define OBJ_MAX_ENTRY 112   // last entry drawn on a line
`define OBJ_LINE_W    448   // visible pixels
`define OBJ_ROM_AW    20    // tile code plus row
`define OBJ_TRANSP    15    // colour never stored

// line buffer address, wraps at 512 so x near 511 folds to the left edge
`define OBJ_BUF_AW    9

`endif

// File: source/obj_pkg.sv
// types shared by the sprite line engine; the attribute layout matches the host table format
`include "obj_defs.svh"

package obj_pkg;

    // stored pixel, all ones means empty
    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] col;
    } obj_pixel_t;

    // attribute word, word 0 of each entry
    typedef struct packed {
        logic [3:0] unused_hi;
        logic [3:0] vsub;       // tile row
        logic       unused_lo;
        logic       vflip;      // not handled here
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_t;

    // host write into the sprite table
    typedef struct packed {
        logic                     we;
        logic [`OBJ_TABLE_AW-1:0] addr;
        logic [15:0]              data;
    } obj_tbl_wr_t;

    // one pixel from the draw engine to the line buffer
    typedef struct packed {
        logic                   we;
        logic [`OBJ_BUF_AW-1:0] addr;
        obj_pixel_t             pxl;
    } obj_buf_wr_t;

endpackage

// File: source/obj_table_ram.sv
// one write and one registered read port; a read of the word being written returns the old value
`timescale 1ns/10ps
`include "obj_defs.svh"

module obj_table_ram (
    input  logic                     clk,
    input  obj_pkg::obj_tbl_wr_t     tbl_wr,
    input  logic [`OBJ_TABLE_AW-1:0] table_addr,
    output logic [15:0]              table_data
);

    localparam int DEPTH = 1 << `OBJ_TABLE_AW;

    // entry n at words 4n..4n+3
    logic [15:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (tbl_wr.we) begin
            mem[tbl_wr.addr] <= tbl_wr.data;   // host side
        end
    end

    // draw side, one cycle latency
    always_ff @(posedge clk) begin
        table_data <= mem[table_addr];
    end

endmodule

// File: source/obj_tile_draw.sv
// start must stay low until done; rom_ok may lag one cycle after an address change
`timescale 1ns/10ps
`include "obj_defs.svh"

module obj_tile_draw (
    input  logic                     rst,
    input  logic                     clk,
    input  logic                     start,
    output logic                     done,
    output logic [`OBJ_TABLE_AW-1:0] table_addr,
    input  logic [15:0]              table_data,
    output obj_pkg::obj_buf_wr_t     buf_wr,
    output logic [`OBJ_ROM_AW-1:0]   rom_addr,
    output logic                     rom_half,
    input  logic [31:0]              rom_data,
    output logic                     rom_cs,
    input  logic                     rom_ok
);

    localparam int ENTRY_W = `OBJ_TABLE_AW - 2;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ADDR,    // table read in flight
        ST_ATTR,
        ST_CODE,
        ST_XPOS,
        ST_FETCH,   // wait for rom_ok
        ST_DRAW,
        ST_SKIP,    // blank half, lets rom_ok settle
        ST_NEXT
    } state_t;

    state_t                 state;
    logic [ENTRY_W-1:0]     entry;
    logic [`OBJ_BUF_AW-1:0] buf_addr;     // next pixel position
    logic [2:0]             pxl_cnt;
    logic                   second;       // working on the second half
    obj_pkg::obj_attr_t     attr;
    logic [31:0]            pxl_data;

    // planar pick, one bit per plane
    function automatic logic [3:0] colour(input logic [31:0] c, input logic flip);
        logic [3:0] res;
        if (flip) begin
            res = {c[24], c[16], c[8], c[0]};
        end else begin
            res = {c[31], c[23], c[15], c[7]};
        end
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            done       <= 1'b0;
            entry      <= '0;
            table_addr <= '0;
            buf_addr   <= '0;
            pxl_cnt    <= '0;
            second     <= 1'b0;
            buf_wr     <= '0;
            rom_addr   <= '0;
            rom_half   <= 1'b0;
            rom_cs     <= 1'b0;
        end else begin
            done      <= 1'b0;
            buf_wr.we <= 1'b0;
            case (state)
                ST_IDLE: begin
                    rom_cs <= 1'b0;
                    if (start) begin
                        entry      <= '0;
                        table_addr <= '0;
                        state      <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    table_addr[1:0] <= 2'd1;
                    state           <= ST_ATTR;
                end
                ST_ATTR: begin
                    table_addr[1:0] <= 2'd2;    // attr latched below
                    state           <= ST_CODE;
                end
                ST_CODE: begin
                    rom_addr <= {table_data, attr.vsub};
                    rom_half <= attr.hflip;     // flipped sprites start on the other half
                    rom_cs   <= 1'b1;
                    state    <= ST_XPOS;
                end
                ST_XPOS: begin
                    buf_addr <= table_data[`OBJ_BUF_AW-1:0];
                    second   <= 1'b0;
                    if (table_data[`OBJ_BUF_AW-1:0] == '0) begin
                        done   <= 1'b1;         // list terminator
                        rom_cs <= 1'b0;
                        state  <= ST_IDLE;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (rom_ok) begin
                        if (!second) begin
                            rom_half <= ~rom_half;
                        end
                        if (&rom_data) begin
                            buf_addr <= buf_addr + `OBJ_BUF_AW'(8);
                            state    <= ST_SKIP;
                        end else begin
                            pxl_cnt <= '0;
                            state   <= ST_DRAW;
                        end
                    end
                end
                ST_DRAW: begin
                    buf_wr.we      <= 1'b1;
                    buf_wr.addr    <= buf_addr;
                    buf_wr.pxl.pal <= attr.pal;
                    buf_wr.pxl.col <= colour(pxl_data, attr.hflip);
                    buf_addr       <= buf_addr + 1'b1;
                    pxl_cnt        <= pxl_cnt + 1'b1;
                    if (pxl_cnt == 3'd7) begin
                        second <= 1'b1;
                        state  <= second ? ST_NEXT : ST_FETCH;
                    end
                end
                ST_SKIP: begin
                    second <= 1'b1;
                    state  <= second ? ST_NEXT : ST_FETCH;
                end
                ST_NEXT: begin
                    if (entry == ENTRY_W'(`OBJ_MAX_ENTRY)) begin
                        done   <= 1'b1;
                        rom_cs <= 1'b0;
                        state  <= ST_IDLE;
                    end else begin
                        entry      <= entry + 1'b1;
                        table_addr <= {entry + 1'b1, 2'd0};
                        state      <= ST_ADDR;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // sprite payload
    always_ff @(posedge clk) begin
        if (state == ST_ATTR) begin
            attr <= obj_pkg::obj_attr_t'(table_data);
        end
        if (state == ST_FETCH && rom_ok) begin
            pxl_data <= rom_data;
        end else if (state == ST_DRAW) begin
            pxl_data <= attr.hflip ? pxl_data >> 1 : pxl_data << 1;
        end
    end

    // the host waits for done before the next start
    start_while_busy: assert property (
        @(posedge clk) disable iff (rst) (state != ST_IDLE) |-> !start
    );

    // request raised at the tile code stays up through every fetch of the sprite
    rom_wait_held: assert property (
        @(posedge clk) disable iff (rst) (state == ST_FETCH) |-> rom_cs
    );

endmodule

// File: source/obj_line_buffer.sv
// banks power up all ones through initial values; line_start only between lines, never mid draw
`timescale 1ns/10ps
`include "obj_defs.svh"

module obj_line_buffer (
    input  logic                   rst,
    input  logic                   clk,
    input  logic                   line_start,
    input  obj_pkg::obj_buf_wr_t   buf_wr,
    input  logic [`OBJ_BUF_AW-1:0] scan_addr,
    input  logic                   scan_rd,
    output obj_pkg::obj_pixel_t    scan_pxl
);

    localparam int DEPTH = 1 << `OBJ_BUF_AW;

    logic                draw_bank;     // scan side uses the other one
    logic                wr_keep;
    obj_pkg::obj_pixel_t bank_rd [2];

    // transparent pixels never reach the RAM
    assign wr_keep = buf_wr.we && (buf_wr.pxl.col != 4'(`OBJ_TRANSP));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_bank <= 1'b0;
        end else if (line_start) begin
            draw_bank <= ~draw_bank;
        end
    end

    // each bank is either the draw target or the scan source
    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic                is_draw;
        obj_pkg::obj_pixel_t mem [DEPTH] = '{default: '1};

        assign is_draw    = (draw_bank == 1'(b));
        assign bank_rd[b] = mem[scan_addr];

        always_ff @(posedge clk) begin
            if (is_draw) begin
                if (wr_keep) begin
                    mem[buf_wr.addr] <= buf_wr.pxl;
                end
            end else if (scan_rd) begin
                mem[scan_addr] <= '1;   // clear behind the read
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_pxl <= '0;
        end else if (scan_rd) begin
            scan_pxl <= bank_rd[!draw_bank];
        end
    end

    // a swap in the middle of drawing would split one line over both banks
    no_write_after_swap: assert property (
        @(posedge clk) disable iff (rst) line_start |=> !buf_wr.we
    );

    // scan stays within the visible part
    scan_in_line: assert property (
        @(posedge clk) disable iff (rst) scan_rd |-> (scan_addr < `OBJ_LINE_W)
    );

endmodule

// File: source/obj_line_engine.sv
// no vertical flip and no layer mixing; ROM is external with its own chip select and ok level
`timescale 1ns/10ps
`include "obj_defs.svh"

module obj_line_engine (
    input  logic                     rst,
    input  logic                     clk,
    // host table writes
    input  obj_pkg::obj_tbl_wr_t     tbl_wr,
    input  logic                     start,
    output logic                     done,
    // scan out
    input  logic                     line_start,
    input  logic [`OBJ_BUF_AW-1:0]   scan_addr,
    input  logic                     scan_rd,
    output obj_pkg::obj_pixel_t      scan_pxl,
    // graphics ROM
    output logic [`OBJ_ROM_AW-1:0]   rom_addr,
    output logic                     rom_half,
    input  logic [31:0]              rom_data,
    output logic                     rom_cs,
    input  logic                     rom_ok
);

    logic [`OBJ_TABLE_AW-1:0] table_addr;
    logic [15:0]              table_data;
    obj_pkg::obj_buf_wr_t     buf_wr;

    obj_table_ram u_table (
        .clk        (clk),
        .tbl_wr     (tbl_wr),
        .table_addr (table_addr),
        .table_data (table_data)
    );

    obj_tile_draw u_draw (
        .rst        (rst),
        .clk        (clk),
        .start      (start),
        .done       (done),
        .table_addr (table_addr),
        .table_data (table_data),
        .buf_wr     (buf_wr),
        .rom_addr   (rom_addr),
        .rom_half   (rom_half),
        .rom_data   (rom_data),
        .rom_cs     (rom_cs),
        .rom_ok     (rom_ok)
    );

    obj_line_buffer u_buffer (
        .rst        (rst),
        .clk        (clk),
        .line_start (line_start),
        .buf_wr     (buf_wr),
        .scan_addr  (scan_addr),
        .scan_rd    (scan_rd),
        .scan_pxl   (scan_pxl)
    );

endmodule

// File: sim/obj_rom_model.sv
// sim only; word is a hash of {addr, half} with every 4th word all ones, latency 1 to 4 cycles
`timescale 1ns/10ps
`include "obj_defs.svh"

module obj_rom_model #(
    parameter logic [15:0] SEED = 16'd17584
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`OBJ_ROM_AW-1:0] rom_addr,
    input  logic                   rom_half,
    input  logic                   rom_cs,
    output logic [31:0]            rom_data,
    output logic                   rom_ok
);

    logic [15:0]          lfsr;
    logic [15:0]          lfsr_mid;     // after the first bit is taken
    logic [2:0]           latency;
    logic [`OBJ_ROM_AW:0] last_req;
    logic                 cs_d;
    logic [2:0]           wait_cnt;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] word_at(input logic [`OBJ_ROM_AW:0] a);
        logic [31:0] h;
        h = {11'd0, a} * 32'h9E37_79B1;
        h = h ^ (h >> 15) ^ 32'h5A3C_96E1;
        return (a[1:0] == 2'b11) ? 32'hFFFF_FFFF : h;   // blank half every 4th word
    endfunction

    assign lfsr_mid = lfsr_step(lfsr);
    assign latency  = 3'd1 + {1'b0, lfsr_mid[0], lfsr[0]};

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr     <= SEED;
            last_req <= '0;
            cs_d     <= 1'b0;
            wait_cnt <= '0;
            rom_ok   <= 1'b0;
            rom_data <= '0;
        end else begin
            cs_d <= rom_cs;
            if (!rom_cs) begin
                rom_ok   <= 1'b0;
                wait_cnt <= '0;
            end else if (({rom_addr, rom_half} != last_req) || !cs_d) begin
                last_req <= {rom_addr, rom_half};   // new request, data not valid yet
                rom_ok   <= 1'b0;
                wait_cnt <= latency;
                lfsr     <= lfsr_step(lfsr_mid);
            end else if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1'b1;
                if (wait_cnt == 3'd1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= word_at(last_req);
                end
            end
        end
    end

endmodule

// File: sim/obj_line_engine_tb.sv
// line reads cover the 448 visible pixels only; the ROM hash here must match the ROM model
`timescale 1ns/10ps
`include "obj_defs.svh"

module obj_line_engine_tb;

    localparam int NCASE    = 5;
    localparam int NROWS    = 12;
    localparam int READ_CYC = 2 * (`OBJ_LINE_W + 2);
    localparam int TIMEOUT  = NCASE * (`OBJ_MAX_ENTRY + 1) * 40
                              + NCASE * (READ_CYC + 4 * 128 + 20) + 16;

    typedef struct packed {
        logic [2:0]  tcase;
        logic [6:0]  entry;
        logic [3:0]  vsub;
        logic        hflip;
        logic [4:0]  pal;
        logic [15:0] code;
        logic [8:0]  x;
    } sprite_row_t;

    logic                  rst;
    logic                  clk;
    obj_pkg::obj_tbl_wr_t  tbl_wr;
    logic                  start;
    logic                  done;
    logic                  line_start;
    logic [8:0]            scan_addr;
    logic                  scan_rd;
    obj_pkg::obj_pixel_t   scan_pxl;
    logic [19:0]           rom_addr;
    logic                  rom_half;
    logic [31:0]           rom_data;
    logic                  rom_cs;
    logic                  rom_ok;

    sprite_row_t rows [NROWS];
    int          fill_cnt [NCASE] = '{0, 0, 0, 0, 128};  // last case fills the whole table
    logic [15:0] shadow [512];                           // host copy of the table
    logic [8:0]  exp_line [512];
    int          n_errors;
    int          n_checks;
    int          cycles;

    obj_line_engine dut0 (
        .rst(rst), .clk(clk), .tbl_wr(tbl_wr), .start(start), .done(done),
        .line_start(line_start), .scan_addr(scan_addr), .scan_rd(scan_rd),
        .scan_pxl(scan_pxl), .rom_addr(rom_addr), .rom_half(rom_half),
        .rom_data(rom_data), .rom_cs(rom_cs), .rom_ok(rom_ok)
    );

    obj_rom_model rom0 (
        .clk(clk), .rst(rst), .rom_addr(rom_addr), .rom_half(rom_half),
        .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("checks %0d, errors %0d", n_checks, n_errors);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic sprite_row_t row(input int tc, input int e, input int vsub,
                                        input int hflip, input int pal,
                                        input logic [15:0] code, input int x);
        return {3'(tc), 7'(e), 4'(vsub), 1'(hflip), 5'(pal), code, 9'(x)};
    endfunction

    function automatic logic [15:0] attr_word(input logic [3:0] vsub, input logic hflip,
                                              input logic [4:0] pal);
        return {4'h0, vsub, 2'b00, hflip, pal};
    endfunction

    function automatic logic [31:0] tile_word(input logic [15:0] code, input logic [3:0] vsub,
                                              input logic half);
        logic [20:0] a;
        logic [31:0] h;
        a = {code, vsub, half};
        h = {11'd0, a} * 32'h9E37_79B1;
        h = h ^ (h >> 15) ^ 32'h5A3C_96E1;
        return (a[1:0] == 2'b11) ? 32'hFFFF_FFFF : h;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_word(input int a, input logic [15:0] d);
        @(posedge clk);
        tbl_wr <= {1'b1, 9'(a), d};
        shadow[a] = d;
    endtask

    task automatic write_sprite(input int e, input logic [15:0] attr, input logic [15:0] code,
                                input logic [8:0] x);
        write_word(4 * e, attr);
        write_word(4 * e + 1, code);
        write_word(4 * e + 2, {7'd0, x});
        write_word(4 * e + 3, 16'h0000);     // spare word
    endtask

    // reference line from the shadow table
    task automatic build_line();
        logic [15:0] attr;
        logic [31:0] w;
        logic [3:0]  col;
        int          x;
        for (int i = 0; i < 512; i++) exp_line[i] = 9'h1FF;
        for (int e = 0; e <= `OBJ_MAX_ENTRY; e++) begin
            attr = shadow[4 * e];
            x    = shadow[4 * e + 2][8:0];
            if (x == 0) break;
            for (int h = 0; h < 2; h++) begin
                w = tile_word(shadow[4 * e + 1], attr[11:8], attr[5] ^ h[0]);
                if (w != 32'hFFFF_FFFF) begin
                    for (int p = 0; p < 8; p++) begin
                        if (attr[5]) col = {w[24 + p], w[16 + p], w[8 + p], w[p]};
                        else         col = {w[31 - p], w[23 - p], w[15 - p], w[7 - p]};
                        if (col != `OBJ_TRANSP) exp_line[(x + 8 * h + p) % 512] = {attr[4:0], col};
                    end
                end
            end
        end
    endtask

    // pixel a is driven on pass a and sampled two edges later
    task automatic read_line(input logic expect_clear);
        for (int i = 0; i < `OBJ_LINE_W + 2; i++) begin
            @(posedge clk);
            if (i >= 2) begin
                compare($sformatf("scan_pxl[%0d]", i - 2), scan_pxl,
                        expect_clear ? 32'h1FF : 32'(exp_line[i - 2]));
            end
            if (i < `OBJ_LINE_W) begin
                scan_rd   <= 1'b1;
                scan_addr <= 9'(i);
            end else begin
                scan_rd <= 1'b0;
            end
        end
    endtask

    initial begin
        clk        = 0;
        rst        = 1;
        tbl_wr     = '0;
        start      = 0;
        line_start = 0;
        scan_addr  = '0;
        scan_rd    = 0;
        n_errors   = 0;
        n_checks   = 0;
        cycles     = 0;
        rows[0]  = row(0, 0, 0, 0, 0, 16'h0000, 0);         // empty list
        rows[1]  = row(1, 0, 2, 0, 3, 16'h0123, 100);
        rows[2]  = row(1, 1, 0, 0, 0, 16'h0000, 0);
        rows[3]  = row(2, 0, 4, 1, 17, 16'h0456, 200);      // hflip
        rows[4]  = row(2, 1, 0, 0, 0, 16'h0000, 0);
        rows[5]  = row(3, 0, 0, 0, 9, 16'h0A11, 300);
        rows[6]  = row(3, 1, 1, 0, 22, 16'h0B22, 306);      // second half blank
        rows[7]  = row(3, 2, 3, 1, 30, 16'h0C33, 296);      // flipped, first half blank
        rows[8]  = row(3, 3, 0, 0, 0, 16'h0000, 0);
        rows[9]  = row(4, 111, 2, 0, 7, 16'h2222, 505);     // wraps to the left edge
        rows[10] = row(4, 112, 6, 1, 12, 16'h3333, 510);
        rows[11] = row(4, 113, 0, 0, 1, 16'hDEAD, 20);      // past the last entry
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare("done", done, 0);
        compare("rom_cs", rom_cs, 0);
        compare("buf_wr.we", dut0.buf_wr.we, 0);
        compare("scan_pxl", scan_pxl, 0);
        for (int c = 0; c < NCASE; c++) begin
            for (int e = 0; e < fill_cnt[c]; e++) begin
                write_sprite(e, attr_word(e[3:0], e[1], e[4:0]), 16'h1000 + 16'(e * 7),
                             9'(1 + (e * 29) % 440));
            end
            for (int r = 0; r < NROWS; r++) begin
                if (rows[r].tcase == c) begin
                    write_sprite(rows[r].entry, attr_word(rows[r].vsub, rows[r].hflip,
                                 rows[r].pal), rows[r].code, rows[r].x);
                end
            end
            @(posedge clk);
            tbl_wr <= '0;
            build_line();
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(posedge clk);
            while (!done) @(posedge clk);
            if (c > 0) read_line(1'b1);      // previous line, already cleared
            @(posedge clk);
            line_start <= 1'b1;
            @(posedge clk);
            line_start <= 1'b0;
            read_line(1'b0);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/obj_pkg.sv
source/obj_table_ram.sv
source/obj_tile_draw.sv
source/obj_line_buffer.sv
source/obj_line_engine.sv
sim/obj_rom_model.sv
sim/obj_line_engine_tb.sv
